// File: run_sim.sh
#!/bin/sh
# Builds the SPI register slave testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
  -f sources.f --top-module spi_regs_tb -o spi_regs_sim
./obj_dir/spi_regs_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "test failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "Simulation ended without a pass report"
  exit 1
fi

// File: sources.f
+incdir+verilog
verilog/spi_frame_pkg.sv
verilog/reg_map_pkg.sv
verilog/spi_shifter.sv
verilog/spi_transaction_ctrl.sv
verilog/reg_bank.sv
verilog/spi_regs_top.sv
test/spi_regs_tb.sv

// File: test/spi_regs_tb.sv
// Testbench for the SPI register slave
// Directed frames from a mode 3 master model, checked against a register model
`timescale 1ns/10ps
`default_nettype none

`include "spi_regs_defs.svh"

module spi_regs_tb;
  import spi_frame_pkg::*;
  import reg_map_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;  // Inputs change this long after a rising edge
  localparam int RESET_CYCLES = 10;
  localparam int NUM_FRAMES   = 11; // Frames issued by all tests together
  localparam int WATCHDOG_NS  = NUM_FRAMES * 10 * 8 * CLK_PERIOD + 4000;
  localparam reg_addr_t CUT_ADDR = 4'd6;

  logic sck;
  logic ss;
  logic clr;
  logic sdin;
  logic mlb;
  logic sdout;
  logic sdout_oe;

  int        seed = 39;                  // Seed for all random data
  spi_byte_t model [`SPI_REGS_COUNT];    // Expected bank contents

  spi_regs_top spi_regs_top_inst (
    .sck      (sck),
    .ss       (ss),
    .clr      (clr),
    .sdin     (sdin),
    .mlb      (mlb),
    .sdout    (sdout),
    .sdout_oe (sdout_oe)
  );

  // Mode 3 idles high, so the clock starts high
  initial begin
    sck = 1'b1;
    forever #(CLK_PERIOD / 2) sck = ~sck;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all frames completed");
    $display("test failed");
    $fatal(1, "Simulation timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "Byte mismatch in %s", name);
    end
  endtask

  task automatic check_oe(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s sdout_oe expected %b actual %b", name, exp, act);
      $display("test failed");
      $fatal(1, "Output enable mismatch in %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Master model
  ////////////////////////////////////////////////////////////////////////////

  // Sends nbits of tx in the order mlb picks, collecting sdout at each rising edge
  task automatic shift_bits(input string name, input spi_byte_t tx, input int nbits,
                            output spi_byte_t rx);
    int         i;
    logic [2:0] idx;
    rx = '0;
    for (i = 0; i < nbits; i++) begin
      idx  = mlb ? 3'(7 - i) : 3'(i);
      sdin = tx[idx];
      @(posedge sck);
      check_oe(name, 1'b1, sdout_oe); // Driven from the first falling edge on
      rx[idx] = sdout;                // sdout only moves on falling edges
      #(DRIVE_DLY);
    end
  endtask

  // Deselected time between frames, with the output released
  task automatic idle_gap(input string name, input int cycles);
    repeat (cycles) begin
      @(posedge sck);
      check_oe(name, 1'b0, sdout_oe);
    end
    #(DRIVE_DLY);
  endtask

  // Selects the slave and sends the command byte, which always returns the chip ID
  task automatic begin_frame(input string name, input logic write, input reg_addr_t addr);
    spi_cmd_t    cmd;
    spi_byte_t   rx;
    logic [31:0] r;
    r            = $random(seed);
    cmd.write    = write;
    cmd.reserved = r[2:0];            // Ignored bits get noise
    cmd.addr     = addr;
    ss           = 1'b0;
    shift_bits(name, spi_byte_t'(cmd), 8, rx);
    check_byte({name, " chip id"}, `SPI_REGS_CHIP_ID, rx);
  endtask

  task automatic end_frame(input string name);
    @(posedge sck);                   // Controller acts on the last done here
    #(DRIVE_DLY);
    ss   = 1'b1;
    sdin = 1'b1;
    idle_gap(name, 2);
  endtask

  task automatic write_burst(input string name, input reg_addr_t addr, input int n);
    int          k;
    reg_addr_t   a;
    spi_byte_t   rx;
    logic [31:0] r;
    a = addr;
    begin_frame(name, 1'b1, addr);
    for (k = 0; k < n; k++) begin
      r = $random(seed);
      shift_bits(name, r[7:0], 8, rx);
      model[a] = r[7:0];
      a = a + reg_addr_t'(1);         // Wraps after 15 like the slave
    end
    end_frame(name);
  endtask

  task automatic read_burst(input string name, input reg_addr_t addr, input int n);
    int        k;
    reg_addr_t a;
    spi_byte_t rx;
    a = addr;
    begin_frame(name, 1'b0, addr);
    for (k = 0; k < n; k++) begin
      shift_bits(name, 8'hFF, 8, rx);
      check_byte(name, model[a], rx);
      a = a + reg_addr_t'(1);
    end
    end_frame(name);
  endtask

  // Data byte cut after 5 bits, so nothing may be stored
  task automatic cut_frame_test();
    spi_byte_t rx;
    begin_frame("cut_frame", 1'b1, CUT_ADDR);
    shift_bits("cut_frame", ~model[CUT_ADDR], 5, rx);
    ss   = 1'b1;
    sdin = 1'b1;
    idle_gap("cut_frame", 2);
    read_burst("cut_frame_readback", CUT_ADDR, 2);
  endtask

  // Bank holds written data here, so one clr edge must bring every register back to zero
  task automatic clear_bank_test();
    clr = 1'b1;
    idle_gap("clear_after_data", 1);
    clr   = 1'b0;
    model = '{default: '0};
    read_burst("clear_after_data", 4'd0, `SPI_REGS_COUNT);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    ss    = 1'b1;
    clr   = 1'b1;
    sdin  = 1'b1;
    mlb   = 1'b1;
    model = '{default: '0}; // Bank is all zero after clr
    idle_gap("reset", RESET_CYCLES);
    clr = 1'b0;

    read_burst("clear_readback", 4'd0, `SPI_REGS_COUNT);
    write_burst("burst_write", 4'd3, 4);
    read_burst("burst_read", 4'd3, 4);
    write_burst("wrap_write", 4'd14, 5);   // Touches 14, 15, 0, 1, 2
    read_burst("wrap_read", 4'd14, 5);

    mlb = 1'b0;                             // Only changed while deselected
    write_burst("lsb_write", 4'd9, 4);
    read_burst("lsb_read", 4'd9, 4);
    read_burst("lsb_read_all", 4'd0, `SPI_REGS_COUNT);
    mlb = 1'b1;

    cut_frame_test();
    clear_bank_test();

    $display("test passed");
    $finish;
  end

endmodule : spi_regs_tb

`default_nettype wire

// File: verilog/reg_bank.sv
// Bank of sixteen 8-bit registers for the SPI slave
// One synchronous write port, one combinational read port and a synchronous clear
`timescale 1ns/10ps
`default_nettype none

`include "spi_regs_defs.svh"

module reg_bank (
  input  logic                     sck,     // Serial clock, also the bank clock
  input  logic                     clr,     // Synchronous clear of every register
  input  logic                     wr_en,   // Write strobe from the controller
  input  reg_map_pkg::reg_addr_t   wr_addr, // Register to write
  input  spi_frame_pkg::spi_byte_t wr_data, // Value to write
  input  reg_map_pkg::reg_addr_t   rd_addr, // Register to read
  output spi_frame_pkg::spi_byte_t rd_data  // Contents of rd_addr
);
  import spi_frame_pkg::*;

  // Contents survive ss, so they outlive a frame
  spi_byte_t regs [`SPI_REGS_COUNT];

  //////////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////////

  // Clear wins over a write in the same cycle
  always_ff @(posedge sck) begin
    if (clr) begin
      regs <= '{default: '0};
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////////

  // Combinational so the byte is ready before the next falling edge
  assign rd_data = regs[rd_addr];

endmodule : reg_bank

`default_nettype wire

// File: verilog/reg_map_pkg.sv
// Register map types for the SPI register slave
// Covers the address, the decoded command byte and the frame states
`default_nettype none

`include "spi_regs_defs.svh"

package reg_map_pkg;

  // Index into the register bank, wraps modulo 16 on increment
  typedef logic [`SPI_REGS_CMD_ADDR_W-1:0] reg_addr_t;

  // Overlay of the first byte of every frame
  // Bit 7 picks the direction, bits 3:0 give the start address
  typedef struct packed {
    logic                                               write;    // 1 = write burst
    logic [`SPI_REGS_CMD_WR_BIT-`SPI_REGS_CMD_ADDR_W-1:0] reserved; // Ignored by the slave
    reg_addr_t                                          addr;     // First register moved
  } spi_cmd_t;

  // Where the controller is within a frame
  typedef enum logic [1:0] {
    XACT_CMD   = 2'd0, // Waiting for the command byte
    XACT_WRITE = 2'd1, // Each further byte is stored
    XACT_READ  = 2'd2  // Each further byte is sent from the bank
  } xact_state_t;

endpackage : reg_map_pkg

`default_nettype wire

// File: verilog/spi_frame_pkg.sv
// Serial frame types shared by the SPI shifter and its users
// Covers the byte, the bit counter and the shifter status report
`default_nettype none

`include "spi_regs_defs.svh"

package spi_frame_pkg;

  // One byte as it moves over sdin or sdout
  typedef logic [`SPI_REGS_BYTE_W-1:0] spi_byte_t;

  // Bits already received in the byte that is in progress
  typedef logic [`SPI_REGS_CNT_W-1:0] bit_cnt_t;

  // What the shifter reports after each completed byte
  // done is a one cycle pulse and rdata keeps the byte until the next one ends
  typedef struct packed {
    logic      done;  // High for one sck cycle after the 8th bit
    spi_byte_t rdata; // Byte assembled from sdin
  } shift_status_t;

endpackage : spi_frame_pkg

`default_nettype wire

// File: verilog/spi_regs_defs.svh
// SPI register slave constants
// Chip identifier, register count and the layout of the command byte
`ifndef SPI_REGS_DEFS_SVH
`define SPI_REGS_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Serial framing
////////////////////////////////////////////////////////////////////////////

`define SPI_REGS_BYTE_W 8       // Bits in one serial byte
`define SPI_REGS_CNT_W 4        // Bit counter width, wide enough to hold 8

////////////////////////////////////////////////////////////////////////////
// Register map and command byte
////////////////////////////////////////////////////////////////////////////

`define SPI_REGS_COUNT 16       // Registers in the bank
`define SPI_REGS_CMD_WR_BIT 7   // Command bit that selects write (1) or read (0)
`define SPI_REGS_CMD_ADDR_W 4   // Start address sits in the low bits of the command

// Sent back to the master while every command byte comes in
`define SPI_REGS_CHIP_ID 8'hA5

`endif

// File: verilog/spi_regs_top.sv
// SPI register slave top level
// Connects the mode 3 shifter, the frame controller and the register bank
`timescale 1ns/10ps
`default_nettype none

module spi_regs_top (
  input  logic sck,      // Serial clock from the master
  input  logic ss,       // Slave select, high deselects
  input  logic clr,      // Synchronous clear of the register bank
  input  logic sdin,     // Serial data from the master
  input  logic mlb,      // Bit order, 1 means MSB first
  output logic sdout,    // Serial data to the master
  output logic sdout_oe  // Drive enable for sdout
);
  import spi_frame_pkg::*;
  import reg_map_pkg::*;

  shift_status_t rx_status; // Byte report from the shifter
  spi_byte_t     tx_byte;   // Byte handed to the shifter
  logic          wr_en;
  reg_addr_t     wr_addr;
  spi_byte_t     wr_data;
  reg_addr_t     rd_addr;
  spi_byte_t     rd_data;

  spi_shifter spi_shifter_inst (
    .sck       (sck),
    .ss        (ss),
    .sdin      (sdin),
    .mlb       (mlb),
    .tx_byte   (tx_byte),
    .rx_status (rx_status),
    .sdout     (sdout),
    .sdout_oe  (sdout_oe)
  );

  spi_transaction_ctrl spi_transaction_ctrl_inst (
    .sck       (sck),
    .ss        (ss),
    .rx_status (rx_status),
    .rd_data   (rd_data),
    .tx_byte   (tx_byte),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr   (rd_addr)
  );

  // Bank runs on sck too but only clr clears it
  reg_bank reg_bank_inst (
    .sck     (sck),
    .clr     (clr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule : spi_regs_top

`default_nettype wire

// File: verilog/spi_shifter.sv
// SPI mode 3 slave shift engine
// Samples sdin on rising sck and updates sdout on falling sck
`timescale 1ns/10ps
`default_nettype none

module spi_shifter (
  input  logic                         sck,       // Serial clock from the master, idles high
  input  logic                         ss,        // Slave select, high deselects and resets
  input  logic                         sdin,      // Serial data from the master
  input  logic                         mlb,       // Bit order, 1 means MSB first
  input  spi_frame_pkg::spi_byte_t     tx_byte,   // Byte to send, taken when the count is zero
  output spi_frame_pkg::shift_status_t rx_status, // Completed byte with its done pulse
  output logic                         sdout,     // Serial data to the master
  output logic                         sdout_oe   // High while this slave drives sdout
);
  import spi_frame_pkg::*;

  spi_byte_t rx_shift; // Receive shift register
  spi_byte_t rx_next;  // Receive register with the current sdin bit added
  spi_byte_t rdata;    // Last complete byte
  spi_byte_t tx_reg;   // Transmit shift register
  bit_cnt_t  bit_cnt;  // Bits received so far in this byte
  logic      done;     // Byte complete pulse
  logic      last_bit; // This rising edge samples bit 8

  //////////////////////////////////////////////////////////////////////////
  // Receive side, rising sck
  //////////////////////////////////////////////////////////////////////////

  // LSB first enters at the top and moves right, MSB first enters at the bottom
  assign rx_next  = mlb ? {rx_shift[6:0], sdin} : {sdin, rx_shift[7:1]};
  assign last_bit = (bit_cnt == bit_cnt_t'($bits(spi_byte_t) - 1));

  // Count and pulse are frame state, so ss clears them and drops a partial byte
  always_ff @(posedge sck or posedge ss) begin
    if (ss) begin
      bit_cnt <= '0;
      done    <= 1'b0;
    end else if (last_bit) begin
      bit_cnt <= '0;             // Next byte starts from zero
      done    <= 1'b1;
    end else begin
      bit_cnt <= bit_cnt + bit_cnt_t'(1);
      done    <= 1'b0;           // Pulse lasts a single cycle
    end
  end

  // Data path only
  always_ff @(posedge sck) begin
    rx_shift <= rx_next;
    if (!ss && last_bit) begin
      rdata <= rx_next;          // Held until the next byte completes
    end
  end

  assign rx_status = '{done: done, rdata: rdata};

  //////////////////////////////////////////////////////////////////////////
  // Transmit side, falling sck
  //////////////////////////////////////////////////////////////////////////

  // A zero count means a new byte starts, otherwise the idle level fills in behind
  always_ff @(negedge sck or posedge ss) begin
    if (ss) begin
      tx_reg   <= 8'hFF;
      sdout_oe <= 1'b0;
    end else begin
      sdout_oe <= 1'b1;          // First falling edge of the frame starts driving
      if (bit_cnt == '0) begin
        tx_reg <= tx_byte;
      end else if (mlb) begin
        tx_reg <= {tx_reg[6:0], 1'b1};
      end else begin
        tx_reg <= {1'b1, tx_reg[7:1]};
      end
    end
  end

  assign sdout = mlb ? tx_reg[7] : tx_reg[0]; // Same bit order as the receive side

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  // The controller acts once per byte, so a stretched pulse would double a write
  a_done_single : assert property (@(posedge sck) disable iff (ss) done |=> !done);

  // Count wraps after bit 8 and never runs past the byte
  a_cnt_range : assert property (@(posedge sck) disable iff (ss)
    bit_cnt <= bit_cnt_t'($bits(spi_byte_t)));

endmodule : spi_shifter

`default_nettype wire

// File: verilog/spi_transaction_ctrl.sv
// Frame controller for the SPI register slave
// Decodes the command byte, walks the address pointer and picks the byte to send
`timescale 1ns/10ps
`default_nettype none

`include "spi_regs_defs.svh"

module spi_transaction_ctrl (
  input  logic                         sck,       // Serial clock
  input  logic                         ss,        // Slave select, high ends the frame
  input  spi_frame_pkg::shift_status_t rx_status, // Byte report from the shifter
  input  spi_frame_pkg::spi_byte_t     rd_data,   // Bank contents at rd_addr
  output spi_frame_pkg::spi_byte_t     tx_byte,   // Next byte for the shifter
  output logic                         wr_en,     // Bank write strobe
  output reg_map_pkg::reg_addr_t       wr_addr,   // Bank write address
  output spi_frame_pkg::spi_byte_t     wr_data,   // Bank write data
  output reg_map_pkg::reg_addr_t       rd_addr    // Bank read address
);
  import spi_frame_pkg::*;
  import reg_map_pkg::*;

  xact_state_t state; // Position within the frame
  reg_addr_t   ptr;   // Register moved by the current data byte
  spi_cmd_t    cmd;   // Received byte viewed as a command

  assign cmd = spi_cmd_t'(rx_status.rdata);

  //////////////////////////////////////////////////////////////////////////
  // Frame state and address pointer
  //////////////////////////////////////////////////////////////////////////

  // Updates at the edge that sees done, one cycle after the byte ends
  always_ff @(posedge sck or posedge ss) begin
    if (ss) begin
      state <= XACT_CMD;
      ptr   <= '0;
    end else if (rx_status.done) begin
      case (state)
        XACT_CMD: begin
          state <= cmd.write ? XACT_WRITE : XACT_READ;
          ptr   <= cmd.addr;        // Burst starts at the command address
        end
        default: begin
          ptr <= ptr + reg_addr_t'(1); // Wraps from 15 to 0
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Bank access and outgoing byte
  //////////////////////////////////////////////////////////////////////////

  // The write lands at the same edge that advances the pointer
  assign wr_en   = (state == XACT_WRITE) && rx_status.done;
  assign wr_addr = ptr;
  assign wr_data = rx_status.rdata;

  // While done is high the pointer still shows the old byte, so look one ahead
  always_comb begin
    if (!rx_status.done) begin
      rd_addr = ptr;
    end else if (state == XACT_CMD) begin
      rd_addr = cmd.addr;            // First data byte of a read
    end else begin
      rd_addr = ptr + reg_addr_t'(1);
    end
  end

  // Chip identifier goes out with the command byte, register data after it
  assign tx_byte = (state == XACT_CMD && !rx_status.done) ? `SPI_REGS_CHIP_ID : rd_data;

  // A write only happens in a write burst and then moves the pointer by one
  a_wr_in_write : assert property (@(posedge sck) disable iff (ss)
    wr_en |-> (state == XACT_WRITE) ##1 (wr_addr == $past(wr_addr) + reg_addr_t'(1)));

endmodule : spi_transaction_ctrl

`default_nettype wire
